// ==== src/hja_consts.svh ====
`ifndef HJA_CONSTS_SVH
`define HJA_CONSTS_SVH

//////////////////////////////
// Register file geometry
//////////////////////////////

// Register address width
`define REG_ADDR_W 4

// Register and data word width
`define REG_VALUE_W 16

// Number of general registers
`define NUM_REGS 16

`endif

// ==== src/hja_pkg.sv ====
`include "hja_consts.svh"

package hja_pkg;

	// ALU opcodes
	typedef enum logic [3:0] {
		OP_ADD  = 4'h0,
		OP_SUB  = 4'h1,
		OP_AND  = 4'h2,
		OP_OR   = 4'h3,
		OP_XOR  = 4'h4,
		OP_SLL  = 4'h5,
		OP_SRA  = 4'h6,
		OP_MOVI = 4'h7
	} alu_op_e;

	// Execute controller states
	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_READ = 2'd1,
		ST_EXE  = 2'd2,
		ST_WB   = 2'd3
	} exec_state_e;

	typedef struct packed {
		alu_op_e                 op;
		logic [`REG_ADDR_W-1:0]  dst;
		logic [`REG_ADDR_W-1:0]  src1;
		logic [`REG_ADDR_W-1:0]  src2;
		logic [`REG_VALUE_W-1:0] imm;
	} exec_cmd_t;

	typedef struct packed {
		logic                    en;
		logic [`REG_ADDR_W-1:0]  addr;
		logic [`REG_VALUE_W-1:0] value;
	} reg_wr_t;

	// Execute stage view for the LED selector
	typedef struct packed {
		logic [`REG_ADDR_W-1:0]  rd_addr1;
		logic [`REG_ADDR_W-1:0]  rd_addr2;
		reg_wr_t                 last_wr;
		logic [`REG_VALUE_W-1:0] op1;
		logic [`REG_VALUE_W-1:0] op2;
		logic [`REG_VALUE_W-1:0] res;
		logic                    zero;
		logic                    busy;
		logic                    done;
		exec_state_e             state;
	} exe_probe_t;

endpackage

// ==== src/hja_regfile.sv ====
`timescale 1ns/10ps
`include "hja_consts.svh"

module hja_regfile (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic [`REG_ADDR_W-1:0]                 rd_addr1,
	input  logic [`REG_ADDR_W-1:0]                 rd_addr2,
	output logic [`REG_VALUE_W-1:0]                rd_value1,
	output logic [`REG_VALUE_W-1:0]                rd_value2,
	input  hja_pkg::reg_wr_t                       wr,
	output logic [`NUM_REGS*`REG_VALUE_W-1:0]      reg_debug_out
);

	logic [`REG_VALUE_W-1:0] regs [`NUM_REGS];

	//////////////////////////////
	// Write port
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.en) begin
			regs[wr.addr] <= wr.value;
		end
	end

	// Read ports without bypass
	assign rd_value1 = regs[rd_addr1];
	assign rd_value2 = regs[rd_addr2];

	// Register 0 sits in the lowest word
	always_comb begin
		for (int i = 0; i < `NUM_REGS; i++) begin
			reg_debug_out[i*`REG_VALUE_W +: `REG_VALUE_W] = regs[i];
		end
	end

	a_wr_addr_known: assert property (
		@(posedge clk) disable iff (reset)
		wr.en |-> !$isunknown(wr.addr)
	) else $error("register write with unknown address");

endmodule

// ==== src/hja_alu.sv ====
`timescale 1ns/10ps
`include "hja_consts.svh"

module hja_alu (
	input  hja_pkg::alu_op_e         op,
	input  logic [`REG_VALUE_W-1:0]  op1,
	input  logic [`REG_VALUE_W-1:0]  op2,
	input  logic [`REG_VALUE_W-1:0]  imm,
	output logic [`REG_VALUE_W-1:0]  res,
	output logic                     zero
);

	import hja_pkg::*;

	// Shift amount from the low nibble of operand 2
	logic [3:0] shamt;

	assign shamt = op2[3:0];

	always_comb begin
		case (op)
			OP_ADD:  res = op1 + op2;
			OP_SUB:  res = op1 - op2;
			OP_AND:  res = op1 & op2;
			OP_OR:   res = op1 | op2;
			OP_XOR:  res = op1 ^ op2;
			OP_SLL:  res = op1 << shamt;
			OP_SRA:  res = $signed(op1) >>> shamt;
			OP_MOVI: res = imm;
			default: res = '0;
		endcase
	end

	assign zero = (res == '0);

endmodule

// ==== src/hja_exec_ctrl.sv ====
`timescale 1ns/10ps
`include "hja_consts.svh"

module hja_exec_ctrl (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     cmd_valid,
	input  hja_pkg::exec_cmd_t       cmd,
	output logic                     busy,
	output logic                     done,
	output logic [`REG_ADDR_W-1:0]   rd_addr1,
	output logic [`REG_ADDR_W-1:0]   rd_addr2,
	input  logic [`REG_VALUE_W-1:0]  rd_value1,
	input  logic [`REG_VALUE_W-1:0]  rd_value2,
	output hja_pkg::alu_op_e         alu_op,
	output logic [`REG_VALUE_W-1:0]  alu_op1,
	output logic [`REG_VALUE_W-1:0]  alu_op2,
	output logic [`REG_VALUE_W-1:0]  alu_imm,
	input  logic [`REG_VALUE_W-1:0]  alu_res,
	input  logic                     alu_zero,
	output hja_pkg::reg_wr_t         wr,
	output hja_pkg::exe_probe_t      probe
);

	import hja_pkg::*;

	exec_state_e             state;
	exec_cmd_t               cmd_q;
	logic [`REG_VALUE_W-1:0] op1_q;
	logic [`REG_VALUE_W-1:0] op2_q;
	logic [`REG_VALUE_W-1:0] res_q;
	logic                    zero_q;
	logic                    done_q;
	reg_wr_t                 last_wr;

	//////////////////////////////
	// State machine
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= ST_IDLE;
			done_q  <= 1'b0;
			last_wr <= '0;
		end else begin
			done_q <= 1'b0;
			case (state)
				ST_IDLE: if (cmd_valid) state <= ST_READ;
				ST_READ: state <= ST_EXE;
				ST_EXE:  state <= ST_WB;
				ST_WB: begin
					state   <= ST_IDLE;
					done_q  <= 1'b1;
					last_wr <= wr;
				end
			endcase
		end
	end

	// Command, operands and result
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && cmd_valid)
			cmd_q <= cmd;
		if (state == ST_READ) begin
			op1_q <= rd_value1;
			op2_q <= rd_value2;
		end
		if (state == ST_EXE) begin
			res_q  <= alu_res;
			zero_q <= alu_zero;
		end
	end

	assign busy     = (state != ST_IDLE);
	assign done     = done_q;
	assign rd_addr1 = cmd_q.src1;
	assign rd_addr2 = cmd_q.src2;
	assign alu_op   = cmd_q.op;
	assign alu_op1  = op1_q;
	assign alu_op2  = op2_q;
	assign alu_imm  = cmd_q.imm;

	// Writeback lands on the WB to IDLE edge
	always_comb begin
		wr.en    = (state == ST_WB);
		wr.addr  = cmd_q.dst;
		wr.value = res_q;
	end

	always_comb begin
		probe.rd_addr1 = cmd_q.src1;
		probe.rd_addr2 = cmd_q.src2;
		probe.last_wr  = last_wr;
		probe.op1      = op1_q;
		probe.op2      = op2_q;
		probe.res      = res_q;
		probe.zero     = zero_q;
		probe.busy     = busy;
		probe.done     = done_q;
		probe.state    = state;
	end

	a_cmd_only_idle: assert property (
		@(posedge clk) disable iff (reset)
		cmd_valid |-> state == ST_IDLE
	) else $error("command strobe while controller busy");

	a_done_single: assert property (
		@(posedge clk) disable iff (reset)
		done |=> !done
	) else $error("done held for more than one cycle");

endmodule

// ==== src/hja_led_ctrl.sv ====
`timescale 1ns/10ps
`include "hja_consts.svh"

module hja_led_ctrl (
	input  logic [15:0]                          sw,
	input  hja_pkg::exe_probe_t                  probe,
	input  logic [`NUM_REGS*`REG_VALUE_W-1:0]    reg_debug_out,
	output logic [15:0]                          led_data
);

	logic [7:0]              sel;
	logic [`REG_ADDR_W-1:0]  reg_idx;
	logic [`REG_VALUE_W-1:0] reg_view;

	assign sel = sw[15:8];

	// 8'h3F is register 0, 8'h30 is register 15
	assign reg_idx  = ~sel[3:0];
	assign reg_view = reg_debug_out[reg_idx*`REG_VALUE_W +: `REG_VALUE_W];

	//////////////////////////////
	// View selector
	//////////////////////////////

	always_comb begin
		case (sel)
			8'h00: led_data = {probe.busy, 1'b0, probe.done, 11'b0, probe.state};
			8'h06: led_data = {probe.last_wr.addr, probe.rd_addr1,
				probe.rd_addr2, probe.last_wr.addr};
			8'h07: led_data = probe.last_wr.value;
			8'h08: led_data = probe.op1;
			8'h09: led_data = probe.op2;
			8'h18: led_data = {probe.last_wr.en, 3'b0, probe.zero, 3'b0,
				probe.last_wr.addr, 4'b0};
			8'h1B: led_data = probe.res;
			default: begin
				// Register window 8'h30 to 8'h3F
				if (sel[7:4] == 4'h3)
					led_data = reg_view;
				else
					led_data = sw;
			end
		endcase
	end

endmodule

// ==== src/hja_debug_top.sv ====
`timescale 1ns/10ps
`include "hja_consts.svh"

module hja_debug_top (
	input  logic                clk,
	input  logic                reset,
	input  logic                cmd_valid,
	input  hja_pkg::exec_cmd_t  cmd,
	output logic                busy,
	output logic                done,
	input  logic [15:0]         sw,
	output logic [15:0]         led_data
);

	import hja_pkg::*;

	logic [`REG_ADDR_W-1:0]               rd_addr1;
	logic [`REG_ADDR_W-1:0]               rd_addr2;
	logic [`REG_VALUE_W-1:0]              rd_value1;
	logic [`REG_VALUE_W-1:0]              rd_value2;
	alu_op_e                              alu_op;
	logic [`REG_VALUE_W-1:0]              alu_op1;
	logic [`REG_VALUE_W-1:0]              alu_op2;
	logic [`REG_VALUE_W-1:0]              alu_imm;
	logic [`REG_VALUE_W-1:0]              alu_res;
	logic                                 alu_zero;
	reg_wr_t                              wr;
	exe_probe_t                           probe;
	logic [`NUM_REGS*`REG_VALUE_W-1:0]    reg_debug_out;

	hja_exec_ctrl ctrl0 (
		.clk(clk), .reset(reset), .cmd_valid(cmd_valid), .cmd(cmd),
		.busy(busy), .done(done),
		.rd_addr1(rd_addr1), .rd_addr2(rd_addr2),
		.rd_value1(rd_value1), .rd_value2(rd_value2),
		.alu_op(alu_op), .alu_op1(alu_op1), .alu_op2(alu_op2), .alu_imm(alu_imm),
		.alu_res(alu_res), .alu_zero(alu_zero),
		.wr(wr), .probe(probe)
	);

	hja_regfile regs0 (
		.clk(clk), .reset(reset),
		.rd_addr1(rd_addr1), .rd_addr2(rd_addr2),
		.rd_value1(rd_value1), .rd_value2(rd_value2),
		.wr(wr), .reg_debug_out(reg_debug_out)
	);

	hja_alu alu0 (
		.op(alu_op), .op1(alu_op1), .op2(alu_op2), .imm(alu_imm),
		.res(alu_res), .zero(alu_zero)
	);

	hja_led_ctrl leds0 (
		.sw(sw), .probe(probe), .reg_debug_out(reg_debug_out), .led_data(led_data)
	);

endmodule

// ==== bench/hja_clkgen.sv ====
`timescale 1ns/10ps

module hja_clkgen (
	output logic clk,
	output logic reset
);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Reset held over two rising edges, released on a falling edge
	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

// ==== bench/hja_tb.sv ====
`timescale 1ns/10ps
`include "hja_consts.svh"

module hja_tb;

	import hja_pkg::*;

	logic clk;
	logic reset;
	logic cmd_valid;
	exec_cmd_t cmd;
	logic busy;
	logic done;
	logic [15:0] sw;
	logic [15:0] led_data;

	// Register model and the view of the last command
	logic [`REG_VALUE_W-1:0] model_regs [`NUM_REGS];
	exec_cmd_t m_cmd;
	logic [`REG_VALUE_W-1:0] m_op1;
	logic [`REG_VALUE_W-1:0] m_op2;
	logic [`REG_VALUE_W-1:0] m_res;
	logic m_zero;
	int phase;
	int seed;

	hja_clkgen clkgen0 (.clk(clk), .reset(reset));

	hja_debug_top dut0 (
		.clk(clk), .reset(reset), .cmd_valid(cmd_valid), .cmd(cmd),
		.busy(busy), .done(done), .sw(sw), .led_data(led_data)
	);

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic logic [`REG_VALUE_W-1:0] alu_ref(input alu_op_e op,
		input logic [15:0] a, input logic [15:0] b, input logic [15:0] imm);
		logic [16:0] sum;
		logic [31:0] wide;
		logic [15:0] r;
		r = '0;
		case (op)
			OP_ADD: begin
				sum = {1'b0, a} + {1'b0, b};
				r = sum[15:0];
			end
			OP_SUB: r = a + (~b) + 16'd1;
			OP_AND: r = a & b;
			OP_OR: r = a | b;
			OP_XOR: r = a ^ b;
			OP_SLL: r = a << b[3:0];
			OP_SRA: begin
				// Sign extend then shift right
				wide = {{16{a[15]}}, a};
				wide = wide >> b[3:0];
				r = wide[15:0];
			end
			OP_MOVI: r = imm;
			default: r = '0;
		endcase
		return r;
	endfunction

	function automatic logic [15:0] led_ref(input logic [15:0] sw_val);
		logic [7:0] sel;
		sel = sw_val[15:8];
		if (sel[7:4] == 4'h3)
			return model_regs[15 - sel[3:0]];
		case (sel)
			8'h00: return 16'h0000;
			8'h06: return {m_cmd.dst, m_cmd.src1, m_cmd.src2, m_cmd.dst};
			8'h07: return m_res;
			8'h08: return m_op1;
			8'h09: return m_op2;
			8'h18: return {1'b1, 3'b0, m_zero, 3'b0, m_cmd.dst, 4'b0};
			8'h1B: return m_res;
			default: return sw_val;
		endcase
	endfunction

	task automatic model_apply(input exec_cmd_t c);
		m_cmd = c;
		m_op1 = model_regs[c.src1];
		m_op2 = model_regs[c.src2];
		m_res = alu_ref(c.op, m_op1, m_op2, c.imm);
		m_zero = (m_res == 16'h0000);
		model_regs[c.dst] = m_res;
	endtask

	//////////////////////////////
	// Compare tasks
	//////////////////////////////

	task automatic check_word(input string name, input logic [`REG_VALUE_W-1:0] exp,
		input logic [`REG_VALUE_W-1:0] act);
		if (act !== exp) begin
			$display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
			$display("=== FAIL ===");
			$fatal(1);
		end
	endtask

	task automatic check_state(input string name, input exec_state_e exp,
		input exec_state_e act);
		if (act !== exp) begin
			$display("CHECK FAILED at %0t ns: %s expected %s, got %s", $time, name,
				exp.name(), act.name());
			$display("=== FAIL ===");
			$fatal(1);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("CHECK FAILED at %0t ns: %s expected %b, got %b", $time, name, exp, act);
			$display("=== FAIL ===");
			$fatal(1);
		end
	endtask

	// Busy and done follow the accepted command
	// Phase 4 is the done cycle
	always @(posedge clk) begin
		if (reset)
			phase <= 0;
		else if ((phase == 0 || phase == 4) && cmd_valid)
			phase <= 1;
		else if (phase == 4)
			phase <= 0;
		else if (phase != 0)
			phase <= phase + 1;
	end

	always @(negedge clk) begin
		if (!reset) begin
			check_bit("busy", phase >= 1 && phase <= 3, busy);
			check_bit("done", phase == 4, done);
		end
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	task automatic check_view(input logic [15:0] sw_val);
		@(negedge clk);
		sw = sw_val;
		#2;
		check_word($sformatf("led_data[sel=%h]", sw_val[15:8]), led_ref(sw_val), led_data);
	endtask

	task automatic run_cmd(input exec_cmd_t c);
		int cnt;
		@(negedge clk);
		cmd = c;
		cmd_valid = 1'b1;
		@(negedge clk);
		cmd_valid = 1'b0;
		cnt = 0;
		while (done !== 1'b1) begin
			if (cnt >= 20) begin
				$display("Timeout: done never came after the command at %0t ns", $time);
				$display("=== FAIL ===");
				$fatal(1);
			end
			@(negedge clk);
			cnt++;
		end
		model_apply(c);
	endtask

	task automatic check_after_cmd();
		check_view({8'h3F - {4'h0, m_cmd.dst}, 8'h00});
		check_view(16'h1B00);
		check_view(16'h1800);
		check_view(16'h0800);
		check_view(16'h0900);
		check_view(16'h0600);
		check_view(16'h0700);
	endtask

	initial begin
		int cnt;
		logic [31:0] r;
		exec_cmd_t c;
		cmd_valid = 1'b0;
		cmd = '0;
		sw = '0;
		seed = 32'h89c1e9d3;
		for (int i = 0; i < `NUM_REGS; i++)
			model_regs[i] = '0;
		cnt = 0;
		while (reset !== 1'b0) begin
			if (cnt >= 10) begin
				$display("Timeout: reset was never released");
				$display("=== FAIL ===");
				$fatal(1);
			end
			@(negedge clk);
			cnt++;
		end

		// Reset state
		check_view(16'h0000);
		for (int i = 0; i < 16; i++)
			check_view({8'h30 + i[7:0], 8'h00});

		// MOVI timing with three busy cycles then done
		@(negedge clk);
		sw = 16'h0000;
		c = '{op: OP_MOVI, dst: 4'd2, src1: 4'd0, src2: 4'd0, imm: 16'hBEEF};
		cmd = c;
		cmd_valid = 1'b1;
		@(negedge clk);
		cmd_valid = 1'b0;
		for (int k = 0; k < 3; k++) begin
			check_bit("busy", 1'b1, busy);
			check_state("state view", exec_state_e'(k + 1), exec_state_e'(led_data[1:0]));
			check_word("led_data[sel=00]", {1'b1, 13'b0, k[1:0] + 2'd1}, led_data);
			@(negedge clk);
		end
		check_bit("done", 1'b1, done);
		check_word("led_data[sel=00]", 16'h2000, led_data);
		model_apply(c);
		check_view(16'h3D00);
		check_word("r2 view", 16'hBEEF, led_data);

		// Random commands
		for (int n = 0; n < 200; n++) begin
			r = $random(seed);
			c.op = alu_op_e'({1'b0, r[2:0]});
			c.dst = r[7:4];
			c.src1 = r[11:8];
			c.src2 = r[15:12];
			r = $random(seed);
			c.imm = r[15:0];
			run_cmd(c);
			check_after_cmd();
		end

		// Unused selectors pass the switches through
		check_view(16'h45A5);
		check_view(16'hFF3C);

		// SUB of equal values gives zero
		run_cmd('{op: OP_MOVI, dst: 4'd1, src1: 4'd0, src2: 4'd0, imm: 16'h1234});
		run_cmd('{op: OP_MOVI, dst: 4'd2, src1: 4'd0, src2: 4'd0, imm: 16'h1234});
		run_cmd('{op: OP_SUB, dst: 4'd3, src1: 4'd1, src2: 4'd2, imm: 16'h0000});
		check_after_cmd();
		check_view(16'h1800);
		check_word("zero flag view", 16'h8830, led_data);

		// ADD overflow wraps
		run_cmd('{op: OP_MOVI, dst: 4'd4, src1: 4'd0, src2: 4'd0, imm: 16'hFFFF});
		run_cmd('{op: OP_MOVI, dst: 4'd5, src1: 4'd0, src2: 4'd0, imm: 16'h0002});
		run_cmd('{op: OP_ADD, dst: 4'd6, src1: 4'd4, src2: 4'd5, imm: 16'h0000});
		check_after_cmd();
		check_view(16'h1B00);
		check_word("add wrap result", 16'h0001, led_data);

		// SRA of a negative value fills with ones
		run_cmd('{op: OP_MOVI, dst: 4'd7, src1: 4'd0, src2: 4'd0, imm: 16'h8000});
		run_cmd('{op: OP_MOVI, dst: 4'd8, src1: 4'd0, src2: 4'd0, imm: 16'h0004});
		run_cmd('{op: OP_SRA, dst: 4'd9, src1: 4'd7, src2: 4'd8, imm: 16'h0000});
		check_after_cmd();
		check_view(16'h3600);
		check_word("sra result", 16'hF800, led_data);

		$display("=== PASS ===");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+src
src/hja_pkg.sv
src/hja_regfile.sv
src/hja_alu.sv
src/hja_exec_ctrl.sv
src/hja_led_ctrl.sv
src/hja_debug_top.sv
bench/hja_clkgen.sv
bench/hja_tb.sv

// ==== Bender.yml ====
package:
  name: hja_debug

sources:
  - include_dirs:
      - src
    files:
      - src/hja_pkg.sv
      - src/hja_regfile.sv
      - src/hja_alu.sv
      - src/hja_exec_ctrl.sv
      - src/hja_led_ctrl.sv
      - src/hja_debug_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/hja_clkgen.sv
      - bench/hja_tb.sv
